// File: common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // pixel format.
    localparam int PIX_W = 8;

    // active frame geometry.
    localparam int H_ACT = 16;
    localparam int V_ACT = 8;

    // pixel count must be a power of two, average is a plain shift.
    localparam int PIX_SHIFT = $clog2(H_ACT * V_ACT);

    // accumulator wide enough for a full frame of 255s.
    localparam int SUM_W = PIX_W + PIX_SHIFT;

    // Q8.8 gains.
    localparam int GAIN_W     = 16;
    localparam int GAIN_FRAC  = 8;
    localparam int GAIN_UNITY = 1 << GAIN_FRAC;

    // multiply stage plus saturate stage.
    localparam int SCALE_LAT = 2;

endpackage : wb_pkg

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module wb_tb \
    -o wb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/wb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

// File: src/wb_top.sv
`default_nettype none

module wb_top (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_vsync,
    input  wire                       i_hsync,
    input  wire                       i_href,
    input  wire  [wb_pkg::PIX_W-1:0]  i_r,
    input  wire  [wb_pkg::PIX_W-1:0]  i_g,
    input  wire  [wb_pkg::PIX_W-1:0]  i_b,
    output wire                       o_vsync,
    output wire                       o_hsync,
    output wire                       o_href,
    output wire  [wb_pkg::PIX_W-1:0]  o_r,
    output wire  [wb_pkg::PIX_W-1:0]  o_g,
    output wire  [wb_pkg::PIX_W-1:0]  o_b
);
    import wb_pkg::*;

    wire [PIX_W-1:0]  avg_r;
    wire [PIX_W-1:0]  avg_g;
    wire [PIX_W-1:0]  avg_b;
    wire              stats_valid;
    wire [GAIN_W-1:0] gain_r;
    wire [GAIN_W-1:0] gain_g;
    wire [GAIN_W-1:0] gain_b;
    wire              gain_load;

    // statistics branch.
    wb_frame_stats u_frame_stats (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_vsync       (i_vsync),
        .i_href        (i_href),
        .i_r           (i_r),
        .i_g           (i_g),
        .i_b           (i_b),
        .o_avg_r       (avg_r),
        .o_avg_g       (avg_g),
        .o_avg_b       (avg_b),
        .o_stats_valid (stats_valid)
    );

    wb_gain_calc u_gain_calc (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stats_valid (stats_valid),
        .i_avg_r       (avg_r),
        .i_avg_g       (avg_g),
        .i_avg_b       (avg_b),
        .o_gain_r      (gain_r),
        .o_gain_g      (gain_g),
        .o_gain_b      (gain_b),
        .o_gain_load   (gain_load)
    );

    // pixel branch.
    wb_pixel_scale u_pixel_scale (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_vsync     (i_vsync),
        .i_hsync     (i_hsync),
        .i_href      (i_href),
        .i_r         (i_r),
        .i_g         (i_g),
        .i_b         (i_b),
        .i_gain_r    (gain_r),
        .i_gain_g    (gain_g),
        .i_gain_b    (gain_b),
        .i_gain_load (gain_load),
        .o_vsync     (o_vsync),
        .o_hsync     (o_hsync),
        .o_href      (o_href),
        .o_r         (o_r),
        .o_g         (o_g),
        .o_b         (o_b)
    );

endmodule : wb_top

`default_nettype wire

// File: tb.f
common/wb_pkg.sv
white_balance/wb_frame_stats.sv
white_balance/wb_gain_calc.sv
white_balance/wb_pixel_scale.sv
src/wb_top.sv
verif/wb_asserts.sv
verif/wb_tb.sv

// File: verif/wb_asserts.sv
`default_nettype none

module wb_asserts (
    input wire                        clk,
    input wire                        i_rst_n,
    input wire                        i_href,
    input wire [wb_pkg::SCALE_LAT-1:0] i_href_pipe,
    input wire [wb_pkg::GAIN_W-1:0]    i_gain_r,
    input wire [wb_pkg::GAIN_W-1:0]    i_gain_g,
    input wire [wb_pkg::GAIN_W-1:0]    i_gain_b,
    input wire                        i_out_href,
    input wire [wb_pkg::PIX_W-1:0]     i_out_r,
    input wire [wb_pkg::PIX_W-1:0]     i_out_g,
    input wire [wb_pkg::PIX_W-1:0]     i_out_b
);
    timeunit 1ns;
    timeprecision 1ps;
    import wb_pkg::*;

    int unsigned fail_count = 0;

    // new gains only land during blanking.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_href || (|i_href_pipe)) |-> $stable({i_gain_r, i_gain_g, i_gain_b}))
        else begin
            fail_count++;
            $error("gain registers changed with active pixels in the pipeline");
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_out_href |-> !$isunknown({i_out_r, i_out_g, i_out_b}))
        else begin
            fail_count++;
            $error("output pixel is unknown while o_href is high");
        end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(i_href) |-> ##SCALE_LAT $rose(i_out_href))
        else begin
            fail_count++;
            $error("o_href did not rise at the pipeline latency");
        end

endmodule : wb_asserts

bind wb_pixel_scale wb_asserts u_asserts (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_href      (i_href),
    .i_href_pipe (href_pipe),
    .i_gain_r    (gain_r_q),
    .i_gain_g    (gain_g_q),
    .i_gain_b    (gain_b_q),
    .i_out_href  (o_href),
    .i_out_r     (o_r),
    .i_out_g     (o_g),
    .i_out_b     (o_b)
);

`default_nettype wire

// File: verif/wb_tb.sv
`default_nettype none

module wb_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import wb_pkg::*;

    localparam int BLANK_CYC  = 100;
    localparam int HS_CYC     = 6;
    localparam int GAP_CYC    = 4;
    localparam int TAIL_CYC   = 10;
    localparam int WAIT_LIMIT = 300;
    localparam int RAND_SEED  = 49088;

    logic             clk;
    logic             i_rst_n;
    logic             i_vsync;
    logic             i_hsync;
    logic             i_href;
    logic [PIX_W-1:0] i_r;
    logic [PIX_W-1:0] i_g;
    logic [PIX_W-1:0] i_b;
    wire              o_vsync;
    wire              o_hsync;
    wire              o_href;
    wire  [PIX_W-1:0] o_r;
    wire  [PIX_W-1:0] o_g;
    wire  [PIX_W-1:0] o_b;

    string names[$];
    int    in_r[$];
    int    in_g[$];
    int    in_b[$];
    int    exp_r[$];
    int    exp_g[$];
    int    exp_b[$];
    int    sync_cnt = 0;
    logic [SCALE_LAT-1:0] vs_hist = '0;
    logic [SCALE_LAT-1:0] hs_hist = '0;
    logic [SCALE_LAT-1:0] hr_hist = '0;

    wb_top wb_top_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_vsync (i_vsync),
        .i_hsync (i_hsync),
        .i_href  (i_href),
        .i_r     (i_r),
        .i_g     (i_g),
        .i_b     (i_b),
        .o_vsync (o_vsync),
        .o_hsync (o_hsync),
        .o_href  (o_href),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_on_error($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        string name;
        int    v[6];
        fd = $fopen("verif/wb_tests.txt", "r");
        if (fd == 0) stop_on_error("cannot open verif/wb_tests.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue; // comment or blank.
            if ($sscanf(line, "%s %d %d %d %d %d %d", name, v[0], v[1], v[2],
                        v[3], v[4], v[5]) != 7) begin
                stop_on_error("malformed line in the test file");
            end
            names.push_back(name);
            in_r.push_back(v[0]);
            in_g.push_back(v[1]);
            in_b.push_back(v[2]);
            exp_r.push_back(v[3]);
            exp_g.push_back(v[4]);
            exp_b.push_back(v[5]);
        end
        $fclose(fd);
        if (names.size() == 0) stop_on_error("the test file holds no frames");
    endtask

    task automatic drive_cycle(input logic vs, input logic hs, input logic hr,
                               input int pr, input int pg, input int pb);
        @(posedge clk);
        #1;
        i_vsync = vs;
        i_hsync = hs;
        i_href  = hr;
        i_r     = PIX_W'(pr);
        i_g     = PIX_W'(pg);
        i_b     = PIX_W'(pb);
    endtask

    task automatic drive_junk(input logic vs, input logic hs);
        drive_cycle(vs, hs, 1'b0, int'($urandom), int'($urandom), int'($urandom));
    endtask

    task automatic drive_frame(input int t);
        int c;
        int ln;
        for (c = 0; c < BLANK_CYC; c++) drive_junk(1'b1, 1'b0);
        for (ln = 0; ln < V_ACT; ln++) begin
            for (c = 0; c < HS_CYC; c++) drive_junk(1'b0, 1'b1);
            for (c = 0; c < GAP_CYC; c++) drive_junk(1'b0, 1'b0);
            for (c = 0; c < H_ACT; c++) drive_cycle(1'b0, 1'b0, 1'b1, in_r[t], in_g[t], in_b[t]);
        end
    endtask

    task automatic drive_all();
        int t;
        int c;
        for (t = 0; t < names.size(); t++) drive_frame(t);
        for (c = 0; c < TAIL_CYC; c++) drive_junk(1'b1, 1'b0); // closes the last frame.
    endtask

    task automatic wait_out_vsync(input logic level);
        int n;
        n = 0;
        while (o_vsync !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_on_error("timeout while waiting for o_vsync");
        end
    endtask

    task automatic check_all();
        int t;
        int n;
        int pixels;
        for (t = 0; t < names.size(); t++) begin
            wait_out_vsync(1'b1);
            wait_out_vsync(1'b0);
            pixels = 0;
            n = 0;
            while (o_vsync !== 1'b1) begin
                if (o_href === 1'b1) begin
                    check_value({names[t], " r"}, exp_r[t], int'(o_r));
                    check_value({names[t], " g"}, exp_g[t], int'(o_g));
                    check_value({names[t], " b"}, exp_b[t], int'(o_b));
                    pixels++;
                end
                @(negedge clk);
                n++;
                if (n > WAIT_LIMIT) stop_on_error("timeout while following o_href in a frame");
            end
            check_value({names[t], " pixels"}, H_ACT * V_ACT, pixels);
        end
    endtask

    // sync outputs against the inputs two cycles back.
    always @(negedge clk) begin
        if (wb_top_inst.u_pixel_scale.u_asserts.fail_count != 0) begin
            stop_on_error("a bound assertion failed in the pixel pipeline");
        end
        if (i_rst_n && sync_cnt >= SCALE_LAT) begin
            check_value("vsync delay", int'(vs_hist[SCALE_LAT-1]), int'(o_vsync));
            check_value("hsync delay", int'(hs_hist[SCALE_LAT-1]), int'(o_hsync));
            check_value("href delay", int'(hr_hist[SCALE_LAT-1]), int'(o_href));
        end
        sync_cnt = i_rst_n ? sync_cnt + 1 : 0;
        vs_hist  = {vs_hist[SCALE_LAT-2:0], i_vsync};
        hs_hist  = {hs_hist[SCALE_LAT-2:0], i_hsync};
        hr_hist  = {hr_hist[SCALE_LAT-2:0], i_href};
    end

    initial begin
        i_rst_n = 1'b0;
        i_vsync = 1'b0;
        i_hsync = 1'b0;
        i_href  = 1'b0;
        i_r     = '0;
        i_g     = '0;
        i_b     = '0;
        void'($urandom(RAND_SEED));
        load_tests();
        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        fork
            drive_all();
            check_all();
        join
        $display("Everything OK");
        $finish;
    end

endmodule : wb_tb

`default_nettype wire

// File: verif/wb_tests.txt
# name  in_r in_g in_b  exp_r exp_g exp_b  (decimal, one frame per line)
# exp is the input scaled by the gains from the previous line's colour
passthrough          200 100  50   200 100  50
same_colour_gray     200 100  50   115 115 115
bright_saturate      100 200 240    57 231 255
zero_red_input         0  50 100     0  44  75
zero_red_unity         0  80 200     0  80 100
white_saturate       255 255 255   255 255 118
white_unity_gains     30  60  90    30  60  90
repeat_cast           30  60  90    60  60  59

// File: white_balance/wb_frame_stats.sv
`default_nettype none

module wb_frame_stats (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_vsync,
    input  wire                       i_href,
    input  wire  [wb_pkg::PIX_W-1:0]  i_r,
    input  wire  [wb_pkg::PIX_W-1:0]  i_g,
    input  wire  [wb_pkg::PIX_W-1:0]  i_b,
    output logic [wb_pkg::PIX_W-1:0]  o_avg_r,
    output logic [wb_pkg::PIX_W-1:0]  o_avg_g,
    output logic [wb_pkg::PIX_W-1:0]  o_avg_b,
    output logic                      o_stats_valid
);
    import wb_pkg::*;

    logic             vsync_d;
    logic             vsync_rise;
    logic             active;
    logic [SUM_W-1:0] sum_r;
    logic [SUM_W-1:0] sum_g;
    logic [SUM_W-1:0] sum_b;

    if ((1 << PIX_SHIFT) != H_ACT * V_ACT) begin : g_bad_geometry
        $error("active pixel count is not a power of two");
    end

    assign vsync_rise = i_vsync & ~vsync_d;
    assign active     = i_href & ~i_vsync;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vsync_d       <= 1'b0;
            o_stats_valid <= 1'b0;
            o_avg_r       <= '0;
            o_avg_g       <= '0;
            o_avg_b       <= '0;
            sum_r         <= '0;
            sum_g         <= '0;
            sum_b         <= '0;
        end else begin
            vsync_d       <= i_vsync;
            o_stats_valid <= vsync_rise;
            if (vsync_rise) begin
                o_avg_r <= sum_r[SUM_W-1 -: PIX_W]; // sum >> PIX_SHIFT.
                o_avg_g <= sum_g[SUM_W-1 -: PIX_W];
                o_avg_b <= sum_b[SUM_W-1 -: PIX_W];
                sum_r   <= '0;
                sum_g   <= '0;
                sum_b   <= '0;
            end else if (active) begin
                sum_r <= sum_r + SUM_W'(i_r);
                sum_g <= sum_g + SUM_W'(i_g);
                sum_b <= sum_b + SUM_W'(i_b);
            end
        end
    end

endmodule : wb_frame_stats

`default_nettype wire

// File: white_balance/wb_gain_calc.sv
`default_nettype none

module wb_gain_calc (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_stats_valid,
    input  wire  [wb_pkg::PIX_W-1:0]   i_avg_r,
    input  wire  [wb_pkg::PIX_W-1:0]   i_avg_g,
    input  wire  [wb_pkg::PIX_W-1:0]   i_avg_b,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_r,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_g,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_b,
    output logic                       o_gain_load
);
    import wb_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DIV_T,
        ST_DIV_R,
        ST_DIV_G,
        ST_DIV_B,
        ST_LOAD
    } state_t;

    state_t                      state;
    logic [$clog2(GAIN_W)-1:0]   div_cnt;
    logic [GAIN_W-1:0]           div_quo;    // dividend shifts out, quotient in.
    logic [PIX_W-1:0]            div_rem;
    logic [PIX_W-1:0]            div_den;
    logic [PIX_W:0]              rem_sh;
    logic [PIX_W+1:0]            trial;
    logic [GAIN_W-1:0]           quo_nxt;
    logic [GAIN_W-1:0]           gain_nxt;
    logic [GAIN_W-1:0]           gray_dvd;
    logic [GAIN_W-1:0]           sum_dvd;
    logic                        last_step;
    logic [PIX_W-1:0]            target;
    logic [GAIN_W-1:0]           res_r;
    logic [GAIN_W-1:0]           res_g;
    logic [GAIN_W-1:0]           res_b;

    always_comb begin
        case (state)
            ST_DIV_R: div_den = i_avg_r;
            ST_DIV_G: div_den = i_avg_g;
            ST_DIV_B: div_den = i_avg_b;
            default:  div_den = PIX_W'(3); // gray target pass.
        endcase
    end

    assign rem_sh    = {div_rem, div_quo[GAIN_W-1]};
    assign trial     = {1'b0, rem_sh} - {2'b00, div_den};
    assign quo_nxt   = {div_quo[GAIN_W-2:0], ~trial[PIX_W+1]};
    assign gain_nxt  = (div_den == '0) ? GAIN_W'(GAIN_UNITY) : quo_nxt;
    assign gray_dvd  = {target, {GAIN_FRAC{1'b0}}};
    assign sum_dvd   = GAIN_W'(i_avg_r) + GAIN_W'(i_avg_g) + GAIN_W'(i_avg_b);
    assign last_step = &div_cnt;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            o_gain_r    <= GAIN_W'(GAIN_UNITY);
            o_gain_g    <= GAIN_W'(GAIN_UNITY);
            o_gain_b    <= GAIN_W'(GAIN_UNITY);
            o_gain_load <= 1'b0;
        end else begin
            o_gain_load <= (state == ST_LOAD); // gains settle with this pulse.
            case (state)
                ST_IDLE:  if (i_stats_valid) state <= ST_DIV_T;
                ST_DIV_T: if (last_step) state <= ST_DIV_R;
                ST_DIV_R: if (last_step) state <= ST_DIV_G;
                ST_DIV_G: if (last_step) state <= ST_DIV_B;
                ST_DIV_B: if (last_step) state <= ST_LOAD;
                ST_LOAD: begin
                    o_gain_r <= res_r;
                    o_gain_g <= res_g;
                    o_gain_b <= res_b;
                    state    <= ST_IDLE;
                end
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // shared restoring divider, one quotient bit per cycle.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            div_quo <= sum_dvd;
            div_rem <= '0;
            div_cnt <= '0;
        end else begin
            div_quo <= quo_nxt;
            div_rem <= trial[PIX_W+1] ? rem_sh[PIX_W-1:0] : trial[PIX_W-1:0];
            div_cnt <= div_cnt + 1'b1;
            if (last_step) begin
                div_rem <= '0;
                case (state)
                    ST_DIV_T: begin
                        target  <= quo_nxt[PIX_W-1:0];
                        div_quo <= {quo_nxt[PIX_W-1:0], {GAIN_FRAC{1'b0}}};
                    end
                    ST_DIV_R: begin
                        res_r   <= gain_nxt;
                        div_quo <= gray_dvd;
                    end
                    ST_DIV_G: begin
                        res_g   <= gain_nxt;
                        div_quo <= gray_dvd;
                    end
                    ST_DIV_B: res_b <= gain_nxt;
                    default: ;
                endcase
            end
        end
    end

endmodule : wb_gain_calc

`default_nettype wire

// File: white_balance/wb_pixel_scale.sv
`default_nettype none

module wb_pixel_scale (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_vsync,
    input  wire                        i_hsync,
    input  wire                        i_href,
    input  wire  [wb_pkg::PIX_W-1:0]   i_r,
    input  wire  [wb_pkg::PIX_W-1:0]   i_g,
    input  wire  [wb_pkg::PIX_W-1:0]   i_b,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_r,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_g,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_b,
    input  wire                        i_gain_load,
    output logic                       o_vsync,
    output logic                       o_hsync,
    output logic                       o_href,
    output logic [wb_pkg::PIX_W-1:0]   o_r,
    output logic [wb_pkg::PIX_W-1:0]   o_g,
    output logic [wb_pkg::PIX_W-1:0]   o_b
);
    import wb_pkg::*;

    logic [GAIN_W-1:0]       gain_r_q;
    logic [GAIN_W-1:0]       gain_g_q;
    logic [GAIN_W-1:0]       gain_b_q;
    logic [PIX_W+GAIN_W-1:0] prod_r;
    logic [PIX_W+GAIN_W-1:0] prod_g;
    logic [PIX_W+GAIN_W-1:0] prod_b;
    logic [SCALE_LAT-1:0]    vsync_pipe;
    logic [SCALE_LAT-1:0]    hsync_pipe;
    logic [SCALE_LAT-1:0]    href_pipe;

    function automatic logic [PIX_W-1:0] saturate(input logic [PIX_W+GAIN_W-1:0] prod);
        if (|prod[PIX_W+GAIN_W-1:PIX_W+GAIN_FRAC]) begin
            return '1;
        end
        return prod[GAIN_FRAC +: PIX_W];
    endfunction

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            gain_r_q   <= GAIN_W'(GAIN_UNITY);
            gain_g_q   <= GAIN_W'(GAIN_UNITY);
            gain_b_q   <= GAIN_W'(GAIN_UNITY);
            vsync_pipe <= '0;
            hsync_pipe <= '0;
            href_pipe  <= '0;
        end else begin
            if (i_gain_load) begin
                gain_r_q <= i_gain_r;
                gain_g_q <= i_gain_g;
                gain_b_q <= i_gain_b;
            end
            vsync_pipe <= {vsync_pipe[SCALE_LAT-2:0], i_vsync};
            hsync_pipe <= {hsync_pipe[SCALE_LAT-2:0], i_hsync};
            href_pipe  <= {href_pipe[SCALE_LAT-2:0], i_href};
        end
    end

    // stage one, products.
    always_ff @(posedge clk) begin
        prod_r <= i_r * gain_r_q;
        prod_g <= i_g * gain_g_q;
        prod_b <= i_b * gain_b_q;
    end

    // stage two, drop fraction and clamp.
    always_ff @(posedge clk) begin
        o_r <= saturate(prod_r);
        o_g <= saturate(prod_g);
        o_b <= saturate(prod_b);
    end

    assign o_vsync = vsync_pipe[SCALE_LAT-1];
    assign o_hsync = hsync_pipe[SCALE_LAT-1];
    assign o_href  = href_pipe[SCALE_LAT-1];

endmodule : wb_pixel_scale

`default_nettype wire
